// ==== common/lar_pkg.sv ====
`default_nettype none

package lar_pkg;

	localparam int LAR_DATA_WIDTH = 256;
	localparam int LAR_ADDR_WIDTH = 27;
	localparam int LAR_OFFSET_WIDTH = 5;

	// elements per line at each integer size
	localparam int LAR_BYTES = LAR_DATA_WIDTH / 8;
	localparam int LAR_HALVES = LAR_DATA_WIDTH / 16;
	localparam int LAR_WORDS = LAR_DATA_WIDTH / 32;
	localparam int LAR_DWORDS = LAR_DATA_WIDTH / 64;

	// encoding equals log2 of the element size in bytes
	typedef enum logic [1:0]
	{
		size_8 = 2'd0,
		size_16 = 2'd1,
		size_32 = 2'd2,
		size_64 = 2'd3
	} int_size_t;

	// one line seen flat or as elements, element 0 in the low bits
	typedef union packed
	{
		logic [LAR_DATA_WIDTH-1:0] flat;
		logic [LAR_BYTES-1:0][7:0] bytes;
		logic [LAR_HALVES-1:0][15:0] halves;
		logic [LAR_WORDS-1:0][31:0] words;
		logic [LAR_DWORDS-1:0][63:0] dwords;
	} lar_line_t;

endpackage

`default_nettype wire

// ==== common/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

	// results of the last three instructions stay visible
	localparam int HISTORY_DEPTH = 3;

	// age values line up with the history slot index
	typedef enum logic [1:0]
	{
		from_age0 = 2'd0,
		from_age1 = 2'd1,
		from_age2 = 2'd2,
		from_file = 2'd3
	} fwd_sel_t;

endpackage

`default_nettype wire

// ==== element_merge/lane_rotator.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_rotator
(
	input lar_pkg::lar_line_t line,
	input logic [lar_pkg::LAR_OFFSET_WIDTH-1:0] amount,
	input lar_pkg::int_size_t size,
	output lar_pkg::lar_line_t rotated
);
	import lar_pkg::*;

	// amount counted in elements, byte bits inside an element dropped
	logic [LAR_OFFSET_WIDTH-2:0] shift_16;
	logic [LAR_OFFSET_WIDTH-3:0] shift_32;
	logic [LAR_OFFSET_WIDTH-4:0] shift_64;

	assign shift_16 = amount[LAR_OFFSET_WIDTH-1:1];
	assign shift_32 = amount[LAR_OFFSET_WIDTH-1:2];
	assign shift_64 = amount[LAR_OFFSET_WIDTH-1:3];

	// rotate left, element i takes the one shift places below it
	always_comb
	begin
		rotated = line;
		case (size)
		size_8:
		begin
			for (int i = 0; i < LAR_BYTES; i++)
			begin
				rotated.bytes[i]
					= line.bytes[LAR_OFFSET_WIDTH'(i - amount)];
			end
		end

		size_16:
		begin
			for (int i = 0; i < LAR_HALVES; i++)
			begin
				rotated.halves[i]
					= line.halves[(LAR_OFFSET_WIDTH-1)'(i - shift_16)];
			end
		end

		size_32:
		begin
			for (int i = 0; i < LAR_WORDS; i++)
			begin
				rotated.words[i]
					= line.words[(LAR_OFFSET_WIDTH-2)'(i - shift_32)];
			end
		end

		size_64:
		begin
			for (int i = 0; i < LAR_DWORDS; i++)
			begin
				rotated.dwords[i]
					= line.dwords[(LAR_OFFSET_WIDTH-3)'(i - shift_64)];
			end
		end
		endcase
	end

endmodule

`default_nettype wire

// ==== element_merge/element_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module element_merge
(
	input lar_pkg::lar_line_t dest,
	input lar_pkg::lar_line_t src,
	input logic [lar_pkg::LAR_OFFSET_WIDTH-1:0] dest_offset,
	input logic [lar_pkg::LAR_OFFSET_WIDTH-1:0] src_offset,
	input lar_pkg::int_size_t size,
	output lar_pkg::lar_line_t merged
);
	import lar_pkg::*;

	logic [LAR_OFFSET_WIDTH-1:0] align;
	logic [LAR_OFFSET_WIDTH-1:0] amount;
	lar_line_t rotated;
	lar_line_t mask;
	lar_line_t inv_mask;

	// both offsets aligned first, else a borrow from the low bits
	// would shift the element distance by one
	assign align = {LAR_OFFSET_WIDTH{1'b1}} << size;
	assign amount = (dest_offset & align) - (src_offset & align);

	lane_rotator rotator
	(
		.line(src),
		.amount(amount),
		.size(size),
		.rotated(rotated)
	);

	// one destination element
	always_comb
	begin
		mask = '0;
		case (size)
		size_8: mask.bytes[dest_offset] = '1;
		size_16: mask.halves[dest_offset[LAR_OFFSET_WIDTH-1:1]] = '1;
		size_32: mask.words[dest_offset[LAR_OFFSET_WIDTH-1:2]] = '1;
		size_64: mask.dwords[dest_offset[LAR_OFFSET_WIDTH-1:3]] = '1;
		endcase
	end

	assign inv_mask.flat = ~mask.flat;
	assign merged.flat = (rotated.flat & mask.flat) | (dest.flat & inv_mask.flat);

	// exactly one element wide, and the two masks split the line
	assert final ($isunknown({dest_offset, size})
		|| ((mask.flat & inv_mask.flat) == '0
		&& (mask.flat | inv_mask.flat) == '1
		&& $countones(mask.flat) == (8 << size)));

endmodule

`default_nettype wire

// ==== hw/operand_forward.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_forward
(
	input logic [lar_pkg::LAR_ADDR_WIDTH-1:0] addr,
	input lar_pkg::lar_line_t file_data,
	input logic [exec_pkg::HISTORY_DEPTH-1:0] age_valid,
	input logic [exec_pkg::HISTORY_DEPTH-1:0][lar_pkg::LAR_ADDR_WIDTH-1:0] age_addr,
	input lar_pkg::lar_line_t [exec_pkg::HISTORY_DEPTH-1:0] age_data,
	output lar_pkg::lar_line_t data,
	output exec_pkg::fwd_sel_t sel
);
	import lar_pkg::*;
	import exec_pkg::*;

	logic [HISTORY_DEPTH-1:0] hit;

	always_comb
	begin
		for (int i = 0; i < HISTORY_DEPTH; i++)
			hit[i] = age_valid[i] && (age_addr[i] == addr);
	end

	// walk oldest to youngest so the youngest match is kept
	always_comb
	begin
		data = file_data;
		sel = from_file;
		for (int i = HISTORY_DEPTH - 1; i >= 0; i--)
		begin
			if (hit[i])
			begin
				data = age_data[i];
				sel = fwd_sel_t'(i);
			end
		end
	end

	// a forwarded line must come from a live slot holding this address
	assert final (sel == from_file
		|| (age_valid[sel] && age_addr[sel] == addr));

endmodule

`default_nettype wire

// ==== hw/result_history.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_history
(
	input logic clk,
	input logic reset,
	input logic wr_valid,
	input logic [lar_pkg::LAR_ADDR_WIDTH-1:0] wr_addr,
	input lar_pkg::lar_line_t wr_data,
	output logic [exec_pkg::HISTORY_DEPTH-1:0] age_valid,
	output logic [exec_pkg::HISTORY_DEPTH-1:0][lar_pkg::LAR_ADDR_WIDTH-1:0] age_addr,
	output lar_pkg::lar_line_t [exec_pkg::HISTORY_DEPTH-1:0] age_data
);
	import lar_pkg::*;
	import exec_pkg::*;

	// slot 0 is the youngest, a bubble shifts in an empty slot
	always_ff @(posedge clk)
	begin
		if (reset)
			age_valid <= '0;
		else
			age_valid <= {age_valid[HISTORY_DEPTH-2:0], wr_valid};
	end

	always_ff @(posedge clk)
	begin
		age_addr <= {age_addr[HISTORY_DEPTH-2:0], wr_addr};
		age_data <= {age_data[HISTORY_DEPTH-2:0], wr_data};
	end

	// unknown valid bits would make forwarding pick garbage
	assert property (@(posedge clk) disable iff (reset)
		!$isunknown(age_valid));

endmodule

`default_nettype wire

// ==== hw/exec_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_stage
(
	input logic clk,
	input logic reset,
	input logic in_valid,
	input logic [lar_pkg::LAR_ADDR_WIDTH-1:0] a_addr,
	input lar_pkg::lar_line_t a_data,
	input logic [lar_pkg::LAR_OFFSET_WIDTH-1:0] a_offset,
	input lar_pkg::int_size_t a_size,
	input logic [lar_pkg::LAR_ADDR_WIDTH-1:0] b_addr,
	input lar_pkg::lar_line_t b_data,
	input logic [lar_pkg::LAR_OFFSET_WIDTH-1:0] b_offset,
	output logic result_valid,
	output logic [lar_pkg::LAR_ADDR_WIDTH-1:0] result_addr,
	output lar_pkg::lar_line_t result_data
);
	import lar_pkg::*;
	import exec_pkg::*;

	logic [HISTORY_DEPTH-1:0] age_valid;
	logic [HISTORY_DEPTH-1:0][LAR_ADDR_WIDTH-1:0] age_addr;
	lar_line_t [HISTORY_DEPTH-1:0] age_data;
	lar_line_t a_line;
	lar_line_t b_line;
	lar_line_t merged;
	fwd_sel_t a_sel;
	fwd_sel_t b_sel;

	operand_forward fwd_a
	(
		.addr(a_addr),
		.file_data(a_data),
		.age_valid(age_valid),
		.age_addr(age_addr),
		.age_data(age_data),
		.data(a_line),
		.sel(a_sel)
	);

	operand_forward fwd_b
	(
		.addr(b_addr),
		.file_data(b_data),
		.age_valid(age_valid),
		.age_addr(age_addr),
		.age_data(age_data),
		.data(b_line),
		.sel(b_sel)
	);

	// b is read at a's element size
	element_merge merge
	(
		.dest(a_line),
		.src(b_line),
		.dest_offset(a_offset),
		.src_offset(b_offset),
		.size(a_size),
		.merged(merged)
	);

	// result lands under a's base address
	result_history history
	(
		.clk(clk),
		.reset(reset),
		.wr_valid(in_valid),
		.wr_addr(a_addr),
		.wr_data(merged),
		.age_valid(age_valid),
		.age_addr(age_addr),
		.age_data(age_data)
	);

	always_ff @(posedge clk)
	begin
		if (reset)
			result_valid <= 1'b0;
		else
			result_valid <= in_valid;
	end

	always_ff @(posedge clk)
	begin
		result_addr <= a_addr;
		result_data <= merged;
	end

	// a live instruction needs known operand fields
	assert property (@(posedge clk) disable iff (reset)
		in_valid |-> !$isunknown({a_addr, a_offset, a_size, b_addr, b_offset}));

	// every age gets forwarded to each operand at some point
	for (genvar g = 0; g < HISTORY_DEPTH; g++)
	begin : g_fwd_cover
		cover property (@(posedge clk) disable iff (reset)
			in_valid && a_sel == fwd_sel_t'(g));
		cover property (@(posedge clk) disable iff (reset)
			in_valid && b_sel == fwd_sel_t'(g));
	end

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock
(
	output logic clk,
	output logic reset
);

	// 4 ns period
	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	initial
	begin
		reset = 1'b1;
		repeat (4)
			@(posedge clk);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== testbench/tb_exec_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_exec_stage;
	import lar_pkg::*;
	import exec_pkg::*;

	logic clk;
	logic reset;
	logic in_valid;
	logic [LAR_ADDR_WIDTH-1:0] a_addr;
	lar_line_t a_data;
	logic [LAR_OFFSET_WIDTH-1:0] a_offset;
	int_size_t a_size;
	logic [LAR_ADDR_WIDTH-1:0] b_addr;
	lar_line_t b_data;
	logic [LAR_OFFSET_WIDTH-1:0] b_offset;
	logic result_valid;
	logic [LAR_ADDR_WIDTH-1:0] result_addr;
	lar_line_t result_data;

	integer seed;
	string test_name;
	int issued;
	int seen;
	logic [LAR_ADDR_WIDTH-1:0] addr_counter;

	// reference history with slot 0 youngest
	logic hist_valid [HISTORY_DEPTH];
	logic [LAR_ADDR_WIDTH-1:0] hist_addr [HISTORY_DEPTH];
	lar_line_t hist_data [HISTORY_DEPTH];

	// register-file lines behind the small address pool
	lar_line_t file_lines [4];

	// expected output staged once for the DUT register and once for the check
	logic pend_valid;
	logic [LAR_ADDR_WIDTH-1:0] pend_addr;
	lar_line_t pend_data;
	logic exp_valid;
	logic [LAR_ADDR_WIDTH-1:0] exp_addr;
	lar_line_t exp_data;

	tb_clock clock_gen
	(
		.clk(clk),
		.reset(reset)
	);

	exec_stage dut
	(
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.a_addr(a_addr),
		.a_data(a_data),
		.a_offset(a_offset),
		.a_size(a_size),
		.b_addr(b_addr),
		.b_data(b_data),
		.b_offset(b_offset),
		.result_valid(result_valid),
		.result_addr(result_addr),
		.result_data(result_data)
	);

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped on the first failed check");
	endtask

	function automatic lar_line_t random_line();
		lar_line_t l;
		for (int i = 0; i < LAR_WORDS; i++)
			l.words[i] = $random(seed);
		return l;
	endfunction

	function automatic int_size_t pick_size();
		logic [31:0] r;
		r = $random(seed);
		return int_size_t'(r[1:0]);
	endfunction

	function automatic logic [LAR_ADDR_WIDTH-1:0] fresh_addr();
		addr_counter = addr_counter + 1'b1;
		return addr_counter;
	endfunction

	// youngest valid slot with the same address or else the file line
	function automatic lar_line_t forwarded_line(input logic [LAR_ADDR_WIDTH-1:0] addr,
		input lar_line_t file_line);
		for (int i = 0; i < HISTORY_DEPTH; i++)
		begin
			if (hist_valid[i] && hist_addr[i] == addr)
				return hist_data[i];
		end
		return file_line;
	endfunction

	// rotating by (d - s) elements puts source element s on lane d
	// and the mask keeps only lane d
	function automatic lar_line_t merged_line(input lar_line_t dst, input lar_line_t src,
		input logic [LAR_OFFSET_WIDTH-1:0] d_off, input logic [LAR_OFFSET_WIDTH-1:0] s_off,
		input int_size_t sz);
		int w;
		int d_idx;
		int s_idx;
		lar_line_t res;
		w = 1 << int'(sz);
		d_idx = int'(d_off) / w;
		s_idx = int'(s_off) / w;
		res = dst;
		for (int k = 0; k < w; k++)
			res.bytes[d_idx * w + k] = src.bytes[s_idx * w + k];
		return res;
	endfunction

	task automatic issue(input logic valid, input logic [LAR_ADDR_WIDTH-1:0] aa,
		input lar_line_t ad, input logic [LAR_OFFSET_WIDTH-1:0] ao, input int_size_t sz,
		input logic [LAR_ADDR_WIDTH-1:0] ba, input lar_line_t bd,
		input logic [LAR_OFFSET_WIDTH-1:0] bo);
		lar_line_t a_line;
		lar_line_t b_line;
		lar_line_t res;
		@(posedge clk);
		a_line = forwarded_line(aa, ad);
		b_line = forwarded_line(ba, bd);
		res = merged_line(a_line, b_line, ao, bo, sz);
		in_valid <= valid;
		a_addr <= aa;
		a_data <= ad;
		a_offset <= ao;
		a_size <= sz;
		b_addr <= ba;
		b_data <= bd;
		b_offset <= bo;
		pend_valid <= valid;
		pend_addr <= aa;
		pend_data <= res;
		for (int i = HISTORY_DEPTH - 1; i > 0; i--)
		begin
			hist_valid[i] = hist_valid[i-1];
			hist_addr[i] = hist_addr[i-1];
			hist_data[i] = hist_data[i-1];
		end
		hist_valid[0] = valid;
		hist_addr[0] = aa;
		hist_data[0] = res;
		if (valid)
			issued++;
	endtask

	task automatic send(input logic [LAR_ADDR_WIDTH-1:0] aa,
		input logic [LAR_ADDR_WIDTH-1:0] ba, input int_size_t sz);
		logic [31:0] r;
		r = $random(seed);
		issue(1'b1, aa, random_line(), r[4:0], sz, ba, random_line(), r[9:5]);
	endtask

	task automatic bubble();
		issue(1'b0, '0, random_line(), '0, size_8, '0, random_line(), '0);
	endtask

	// producer then gap fillers or bubbles then a consumer of its line
	task automatic forward_case(input int gap, input bit on_b, input bit with_bubbles);
		logic [LAR_ADDR_WIDTH-1:0] x;
		x = fresh_addr();
		send(x, fresh_addr(), pick_size());
		for (int i = 0; i < gap; i++)
		begin
			if (with_bubbles)
				bubble();
			else
				send(fresh_addr(), fresh_addr(), pick_size());
		end
		if (on_b)
			send(fresh_addr(), x, pick_size());
		else
			send(x, fresh_addr(), pick_size());
	endtask

	// pattern bit k writes x so that it sits at age k for the consumer
	task automatic youngest_case(input logic [2:0] pattern);
		logic [LAR_ADDR_WIDTH-1:0] x;
		x = fresh_addr();
		for (int k = 2; k >= 0; k--)
		begin
			if (pattern[k])
				send(x, fresh_addr(), pick_size());
			else
				bubble();
		end
		send(x, x, pick_size());
	endtask

	always @(posedge clk)
	begin
		exp_valid <= pend_valid;
		exp_addr <= pend_addr;
		exp_data <= pend_data;
		if (!reset && result_valid)
			seen <= seen + 1;
	end

	assert property (@(posedge clk) disable iff (reset) result_valid == exp_valid)
	else
		stop_run($sformatf("[ERROR] %s: result_valid expected %0b, actual %0b",
			test_name, $sampled(exp_valid), $sampled(result_valid)));

	assert property (@(posedge clk) disable iff (reset)
		result_valid |-> result_addr == exp_addr)
	else
		stop_run($sformatf("[ERROR] %s: result_addr expected %h, actual %h",
			test_name, $sampled(exp_addr), $sampled(result_addr)));

	assert property (@(posedge clk) disable iff (reset)
		result_valid |-> result_data == exp_data)
	else
		stop_run($sformatf("[ERROR] %s: result_data expected %h, actual %h",
			test_name, $sampled(exp_data), $sampled(result_data)));

	initial
	begin
		int cycles;
		logic [31:0] r;
		seed = 30164;
		test_name = "reset";
		issued = 0;
		seen = 0;
		addr_counter = 27'h100;
		in_valid <= 1'b0;
		a_addr <= '0;
		a_data <= '0;
		a_offset <= '0;
		a_size <= size_8;
		b_addr <= '0;
		b_data <= '0;
		b_offset <= '0;
		pend_valid = 1'b0;
		pend_addr = '0;
		pend_data = '0;
		exp_valid = 1'b0;
		exp_addr = '0;
		exp_data = '0;
		for (int i = 0; i < HISTORY_DEPTH; i++)
		begin
			hist_valid[i] = 1'b0;
			hist_addr[i] = '0;
			hist_data[i] = '0;
		end
		for (int i = 0; i < 4; i++)
			file_lines[i] = random_line();

		cycles = 0;
		do
		begin
			@(posedge clk);
			cycles++;
		end
		while (reset && cycles < 50);
		if (reset)
			stop_run("timeout: reset was never released");

		test_name = "idle_after_reset";
		repeat (4)
			bubble();

		test_name = "no_forward";
		for (int i = 0; i < 48; i++)
			send(fresh_addr(), fresh_addr(), int_size_t'(i % 4));

		test_name = "forward_fillers";
		for (int gap = 0; gap < 4; gap++)
		begin
			forward_case(gap, 1'b0, 1'b0);
			forward_case(gap, 1'b1, 1'b0);
		end

		test_name = "forward_bubbles";
		for (int gap = 0; gap < 5; gap++)
		begin
			forward_case(gap, 1'b0, 1'b1);
			forward_case(gap, 1'b1, 1'b1);
		end

		test_name = "youngest_wins";
		for (int p = 1; p < 8; p++)
			youngest_case(3'(p));

		// small address pool so matches pile up in the history
		test_name = "random_mix";
		for (int i = 0; i < 300; i++)
		begin
			r = $random(seed);
			if (r[1:0] == 2'd0)
				bubble();
			else
			begin
				if (r[4:2] == 3'd0)
					file_lines[r[6:5]] = random_line();
				issue(1'b1, 27'h10 + r[9:8], file_lines[r[9:8]], r[16:12],
					int_size_t'(r[18:17]), 27'h10 + r[11:10], file_lines[r[11:10]],
					r[23:19]);
			end
		end

		test_name = "drain";
		cycles = 0;
		while (seen != issued && cycles < 20)
		begin
			bubble();
			cycles++;
		end
		if (seen != issued)
			stop_run($sformatf("timeout: %0d results seen for %0d instructions",
				seen, issued));
		else
		begin
			repeat (2)
				bubble();
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
common/lar_pkg.sv
common/exec_pkg.sv
element_merge/lane_rotator.sv
element_merge/element_merge.sv
hw/operand_forward.sv
hw/result_history.sv
hw/exec_stage.sv
testbench/tb_clock.sv
testbench/tb_exec_stage.sv
